// ==== pi_emu_macros.svh ====
`ifndef PI_EMU_MACROS_SVH
`define PI_EMU_MACROS_SVH

// width of a timestep or delay in ps
`define DT_WIDTH 16

// width of the absolute emulated time counter in ps
`define TIME_WIDTH 32

// interpolator code width
`define NBIT 9

// intrinsic delay of the interpolator in ps
`define PI_OFFSET 20

// width of the jitter bound in ps
`define JIT_WIDTH 7

// reset value of the jitter LFSR, must be nonzero
`define LFSR_SEED 16'hace1

`endif

// ==== pi_emu_pkg.sv ====
`include "pi_emu_macros.svh"

package pi_emu_pkg;

    // timestep or delay in ps
    typedef logic [`DT_WIDTH-1:0] dt_t;

    // absolute emulated time in ps
    typedef logic [`TIME_WIDTH-1:0] emu_time_t;

    // phase interpolator control code
    typedef logic [`NBIT-1:0] pi_code_t;

    // upper bound of the added jitter in ps
    typedef logic [`JIT_WIDTH-1:0] jit_amp_t;

endpackage

// ==== clk_src_model.sv ====
`timescale 1ns/1ps

module clk_src_model import pi_emu_pkg::*; (
    input  logic emu_clk,
    input  logic rst,
    input  dt_t  half_period,
    input  dt_t  emu_dt,
    output logic clk_val,
    output dt_t  dt_req
);

    // ps left until the next toggle of the emulated clock
    dt_t rem;

    always_ff @(posedge emu_clk) begin
        if (rst) begin
            clk_val <= 1'b0;
            rem     <= half_period;
        end else if (emu_dt == rem) begin
            // toggle lands exactly on this step
            clk_val <= ~clk_val;
            rem     <= half_period;
        end else begin
            rem <= rem - emu_dt;
        end
    end

    assign dt_req = rem;

    // the time manager must never step past our next toggle
    a_no_overshoot: assert property (
        @(posedge emu_clk) disable iff (rst)
        emu_dt <= dt_req
    ) else $error("clk_src_model: emu_dt %0d exceeds dt_req %0d", emu_dt, dt_req);

    // a zero half period would stall emulated time
    a_half_period_nonzero: assert property (
        @(posedge emu_clk) disable iff (rst)
        half_period != '0
    ) else $error("clk_src_model: half_period is zero");

endmodule

// ==== clk_delay_core.sv ====
`timescale 1ns/1ps

module clk_delay_core import pi_emu_pkg::*; (
    input  logic emu_clk,
    input  logic rst,
    input  logic clk_i_val,
    input  dt_t  delay,
    input  dt_t  emu_dt,
    output logic clk_o_val,
    output dt_t  dt_req
);

    logic clk_i_prev;
    logic in_edge;
    logic pending;
    logic target;
    dt_t  rem;

    // either direction counts as an event
    assign in_edge = clk_i_val ^ clk_i_prev;

    always_ff @(posedge emu_clk) begin
        if (rst) begin
            clk_i_prev <= 1'b0;
        end else begin
            clk_i_prev <= clk_i_val;
        end
    end

    // an edge is visible in the cycle whose emu_time equals the input toggle time,
    // so the countdown starts from the full delay minus this cycle's step
    always_ff @(posedge emu_clk) begin
        if (rst) begin
            clk_o_val <= 1'b0;
            pending   <= 1'b0;
        end else if (in_edge) begin
            if (emu_dt == delay) begin
                // delay consumed in a single step
                clk_o_val <= clk_i_val;
                pending   <= 1'b0;
            end else begin
                pending <= 1'b1;
            end
        end else if (pending && (emu_dt == rem)) begin
            clk_o_val <= target;
            pending   <= 1'b0;
        end
    end

    // countdown to the pending output edge and the level it drives
    always_ff @(posedge emu_clk) begin
        if (in_edge) begin
            rem    <= delay - emu_dt;
            target <= clk_i_val;
        end else if (pending) begin
            rem <= rem - emu_dt;
        end
    end

    // request built from registered state and the delay level only,
    // never from emu_dt, so no loop through the time manager
    always_comb begin
        if (in_edge) begin
            dt_req = delay;
        end else if (pending) begin
            dt_req = rem;
        end else begin
            // idle with nothing to schedule
            dt_req = '1;
        end
    end

    // delay stays below the input half period so at most one output edge is pending
    a_single_pending: assert property (
        @(posedge emu_clk) disable iff (rst)
        in_edge |-> !pending
    ) else $error("clk_delay_core: input edge while an output edge is pending");

    a_no_overshoot: assert property (
        @(posedge emu_clk) disable iff (rst)
        pending |-> (emu_dt <= rem)
    ) else $error("clk_delay_core: emu_dt %0d overshoots pending edge %0d", emu_dt, rem);

endmodule

// ==== phase_interpolator.sv ====
`timescale 1ns/1ps
`include "pi_emu_macros.svh"

module phase_interpolator import pi_emu_pkg::*; (
    input  logic     emu_clk,
    input  logic     rst,
    input  logic     clk_in,
    input  logic     ctl_valid,
    input  pi_code_t ctl,
    input  jit_amp_t jitter_amp,
    input  dt_t      emu_dt,
    output logic     clk_out_slice,
    output dt_t      dt_req
);

    pi_code_t                code;
    logic [15:0]             lfsr;
    logic                    clk_in_prev;
    logic [`JIT_WIDTH:0]     jit_mod;
    logic [`JIT_WIDTH-1:0]   jitter;
    dt_t                     delay;

    // code takes effect for edges detected after the strobe cycle
    always_ff @(posedge emu_clk) begin
        if (rst) begin
            code <= '0;
        end else if (ctl_valid) begin
            code <= ctl;
        end
    end

    // fibonacci lfsr, taps 16 14 13 11, one step per input edge
    always_ff @(posedge emu_clk) begin
        if (rst) begin
            lfsr        <= `LFSR_SEED;
            clk_in_prev <= 1'b0;
        end else begin
            clk_in_prev <= clk_in;
            if (clk_in ^ clk_in_prev) begin
                lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            end
        end
    end

    // uniform-ish jitter in 0..jitter_amp
    assign jit_mod = {1'b0, jitter_amp} + 1'b1;
    assign jitter  = `JIT_WIDTH'(lfsr % jit_mod);

    assign delay = dt_t'(`PI_OFFSET) + dt_t'(code) + dt_t'(jitter);

    clk_delay_core clk_delay_core_i (
        .emu_clk   (emu_clk),
        .rst       (rst),
        .clk_i_val (clk_in),
        .delay     (delay),
        .emu_dt    (emu_dt),
        .clk_o_val (clk_out_slice),
        .dt_req    (dt_req)
    );

endmodule

// ==== emu_time_mgr.sv ====
`timescale 1ns/1ps

module emu_time_mgr import pi_emu_pkg::*; (
    input  logic      emu_clk,
    input  logic      rst,
    input  dt_t       dt_req_src,
    input  dt_t       dt_req_pi,
    input  dt_t       dt_req_max,
    output dt_t       emu_dt,
    output emu_time_t emu_time
);

    dt_t dt_model;

    // smallest request wins so that no model event is skipped
    always_comb begin
        dt_model = (dt_req_src < dt_req_pi) ? dt_req_src : dt_req_pi;
        emu_dt   = (dt_model < dt_req_max) ? dt_model : dt_req_max;
    end

    always_ff @(posedge emu_clk) begin
        if (rst) begin
            emu_time <= '0;
        end else begin
            emu_time <= emu_time + emu_time_t'(emu_dt);
        end
    end

    // a zero step would freeze emulated time
    a_dt_nonzero: assert property (
        @(posedge emu_clk) disable iff (rst)
        emu_dt != '0
    ) else $error("emu_time_mgr: granted a zero timestep");

endmodule

// ==== pi_emu_top.sv ====
`timescale 1ns/1ps

module pi_emu_top import pi_emu_pkg::*; (
    input  logic      emu_clk,
    input  logic      rst,
    input  dt_t       half_period,
    input  dt_t       dt_req_max,
    input  logic      ctl_valid,
    input  pi_code_t  ctl,
    input  jit_amp_t  jitter_amp,
    output logic      clk_in_val,
    output logic      clk_out_val,
    output dt_t       emu_dt,
    output emu_time_t emu_time
);

    dt_t dt_req_src;
    dt_t dt_req_pi;

    clk_src_model clk_src_model_i (
        .emu_clk     (emu_clk),
        .rst         (rst),
        .half_period (half_period),
        .emu_dt      (emu_dt),
        .clk_val     (clk_in_val),
        .dt_req      (dt_req_src)
    );

    phase_interpolator phase_interpolator_i (
        .emu_clk       (emu_clk),
        .rst           (rst),
        .clk_in        (clk_in_val),
        .ctl_valid     (ctl_valid),
        .ctl           (ctl),
        .jitter_amp    (jitter_amp),
        .emu_dt        (emu_dt),
        .clk_out_slice (clk_out_val),
        .dt_req        (dt_req_pi)
    );

    emu_time_mgr emu_time_mgr_i (
        .emu_clk    (emu_clk),
        .rst        (rst),
        .dt_req_src (dt_req_src),
        .dt_req_pi  (dt_req_pi),
        .dt_req_max (dt_req_max),
        .emu_dt     (emu_dt),
        .emu_time   (emu_time)
    );

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic emu_clk,
    output logic rst
);

    // 100 ns emulation clock
    initial begin
        emu_clk = 1'b0;
        forever #50 emu_clk = ~emu_clk;
    end

    // reset held for 4 rising edges, released just after the edge
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge emu_clk);
        #1;
        rst = 1'b0;
    end

endmodule

// ==== tb_pi_emu.sv ====
`timescale 1ns/1ps
`include "pi_emu_macros.svh"

module tb_pi_emu import pi_emu_pkg::*; ();

    localparam int ROWS            = 8;
    localparam int TOGGLES_PER_ROW = 32;
    localparam int WATCHDOG_CYCLES = ROWS * 16 * 2 * 600;

    typedef struct packed {
        pi_code_t ctl;
        pi_code_t ctl_mid;
        jit_amp_t jit;
        dt_t      hp;
        dt_t      dt_max;
    } row_t;

    // one input edge waiting for its delayed output edge
    typedef struct packed {
        emu_time_t t_in;
        dt_t       lo;
        dt_t       hi;
        logic      lvl;
    } edge_rec_t;

    logic      emu_clk;
    logic      rst;
    dt_t       half_period;
    dt_t       dt_req_max;
    logic      ctl_valid;
    pi_code_t  ctl;
    jit_amp_t  jitter_amp;
    logic      clk_in_val;
    logic      clk_out_val;
    dt_t       emu_dt;
    emu_time_t emu_time;

    row_t        rows [ROWS];
    edge_rec_t   pend_q [$];
    logic [15:0] lfsr_state;
    int          in_toggles;
    int          gap;

    logic      in_prev;
    logic      out_prev;
    logic      have_prev;
    logic      strobe_seen;
    pi_code_t  code_model;
    pi_code_t  strobe_code;
    dt_t       hp_expect;
    dt_t       hp_last;
    dt_t       prev_dt;
    emu_time_t t_prev_in;
    emu_time_t prev_time;

    tb_clk_gen i_clk_gen (
        .emu_clk (emu_clk),
        .rst     (rst)
    );

    pi_emu_top i_dut (
        .emu_clk     (emu_clk),
        .rst         (rst),
        .half_period (half_period),
        .dt_req_max  (dt_req_max),
        .ctl_valid   (ctl_valid),
        .ctl         (ctl),
        .jitter_amp  (jitter_amp),
        .clk_in_val  (clk_in_val),
        .clk_out_val (clk_out_val),
        .emu_dt      (emu_dt),
        .emu_time    (emu_time)
    );

    task automatic check_value(input string what, input longint got, input longint expected);
        if (got !== expected) begin
            $display("FAIL at %0t: %s, got %0d expected %0d", $time, what, got, expected);
            $display("test failed");
            $fatal(1, "mismatch");
        end
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        // taps 16 15 13 4
        return {s[14:0], s[15] ^ s[14] ^ s[12] ^ s[3]};
    endfunction

    task automatic random_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = (val << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic step_cycle();
        @(posedge emu_clk);
        #1;
    endtask

    task automatic fill_table();
        // ctl, ctl_mid, jitter_amp, half_period, dt_req_max
        rows[0] = '{9'd0,   9'd0,   7'd0,   16'd100, 16'd1000};
        rows[1] = '{9'd40,  9'd60,  7'd0,   16'd150, 16'd37};
        rows[2] = '{9'd100, 9'd100, 7'd30,  16'd200, 16'd500};
        rows[3] = '{9'd300, 9'd250, 7'd0,   16'd450, 16'd64};
        rows[4] = '{9'd200, 9'd200, 7'd100, 16'd400, 16'd1000};
        rows[5] = '{9'd511, 9'd400, 7'd0,   16'd600, 16'd9};
        rows[6] = '{9'd450, 9'd450, 7'd100, 16'd600, 16'd300};
        rows[7] = '{9'd5,   9'd0,   7'd0,   16'd30,  16'd1000};
    endtask

    // sampled mid-cycle, where every DUT output is settled
    always @(negedge emu_clk) begin : edge_monitor
        edge_rec_t rec;
        longint    d;
        if (rst !== 1'b0) begin
            in_prev     = 1'b0;
            out_prev    = 1'b0;
            have_prev   = 1'b0;
            strobe_seen = 1'b0;
            code_model  = '0;
            hp_expect   = half_period;
            hp_last     = half_period;
            t_prev_in   = '0;
            in_toggles  = 0;
        end else begin
            // a strobe seen last cycle was latched at the edge just passed
            if (strobe_seen) begin
                code_model = strobe_code;
            end
            check_value("emu_dt within dt_req_max", longint'(emu_dt <= dt_req_max), 1);
            if (have_prev) begin
                check_value("emu_time advance", longint'(emu_time),
                            longint'(prev_time) + longint'(prev_dt));
            end
            prev_time = emu_time;
            prev_dt   = emu_dt;
            have_prev = 1'b1;
            if (clk_out_val != out_prev) begin
                check_value("output toggle has a pending input edge",
                            longint'(pend_q.size() != 0), 1);
                rec = pend_q.pop_front();
                d   = longint'(emu_time) - longint'(rec.t_in);
                check_value("output toggle direction", longint'(clk_out_val), longint'(rec.lvl));
                if (rec.hi == rec.lo) begin
                    check_value("output delay", d, longint'(rec.lo));
                end else begin
                    check_value("output delay inside jitter window",
                                longint'((d >= longint'(rec.lo)) && (d <= longint'(rec.hi))), 1);
                end
            end
            if (clk_in_val != in_prev) begin
                check_value("input half period", longint'(emu_time - t_prev_in),
                            longint'(hp_expect));
                // the source reloaded the value it saw during the last cycle
                hp_expect = hp_last;
                t_prev_in = emu_time;
                rec.t_in  = emu_time;
                rec.lo    = dt_t'(`PI_OFFSET) + dt_t'(code_model);
                rec.hi    = rec.lo + dt_t'(jitter_amp);
                rec.lvl   = clk_in_val;
                pend_q.push_back(rec);
                in_toggles++;
            end
            in_prev     = clk_in_val;
            out_prev    = clk_out_val;
            strobe_seen = ctl_valid;
            strobe_code = ctl;
            hp_last     = half_period;
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge emu_clk);
        $display("timeout: the table did not finish within %0d emulation cycles", WATCHDOG_CYCLES);
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin : main
        int target;
        fill_table();
        lfsr_state  = 16'd9110;
        ctl_valid   = 1'b0;
        ctl         = '0;
        jitter_amp  = rows[0].jit;
        half_period = rows[0].hp;
        dt_req_max  = rows[0].dt_max;
        @(negedge rst);
        @(negedge emu_clk);
        check_value("clk_in_val after reset", longint'(clk_in_val), 0);
        check_value("clk_out_val after reset", longint'(clk_out_val), 0);
        check_value("emu_time after reset", longint'(emu_time), 0);
        for (int r = 0; r < ROWS; r++) begin
            step_cycle();
            target      = in_toggles;
            ctl         = rows[r].ctl;
            ctl_valid   = 1'b1;
            jitter_amp  = rows[r].jit;
            half_period = rows[r].hp;
            dt_req_max  = rows[r].dt_max;
            step_cycle();
            ctl_valid = 1'b0;
            while (in_toggles < target + TOGGLES_PER_ROW / 2) step_cycle();
            // code change somewhere in the middle of the row
            random_bits(2, gap);
            repeat (gap) step_cycle();
            ctl       = rows[r].ctl_mid;
            ctl_valid = 1'b1;
            step_cycle();
            ctl_valid = 1'b0;
            while (in_toggles < target + TOGGLES_PER_ROW) step_cycle();
        end
        while (pend_q.size() != 0) step_cycle();
        $display("test passed");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+.
pi_emu_pkg.sv
clk_src_model.sv
clk_delay_core.sv
phase_interpolator.sv
emu_time_mgr.sv
pi_emu_top.sv
tb_clk_gen.sv
tb_pi_emu.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_pi_emu -f verilog.f

# a failing run stops with a nonzero status, the search below decides
output=$(./obj_dir/Vtb_pi_emu) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "test passed"; then
    exit 0
fi
exit 1
